// ==== rtl/ipv4_checksum_verify.sv ====
//////////////////////////////
// IPv4 header checksum verifier, two-stage sum and fold
//////////////////////////////

module ipv4_checksum_verify (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  req,
    input  ipv4_hdr_pkg::ipv4_hdr_t hdr,
    ipv4_stat_if.src              stat
);

    import ipv4_hdr_pkg::*;

    logic [CSUM_W-1:0] words [10];
    logic [SUM_W-1:0]  sum_c;
    logic [SUM_W-1:0]  sum_q;
    logic              valid_q;

    //////////////////////////////
    // Header words
    //////////////////////////////

    // The checksum word is summed too, a clean header folds to all ones
    always_comb begin
        words[0] = {IPV4_VER_IHL, hdr.dscp, hdr.ecn};
        words[1] = hdr.length;
        words[2] = hdr.identification;
        words[3] = {hdr.flags, hdr.frag_offset};
        words[4] = {hdr.ttl, hdr.protocol};
        words[5] = hdr.hdr_chksum;
        words[6] = hdr.src_ip[31:16];
        words[7] = hdr.src_ip[15:0];
        words[8] = hdr.dst_ip[31:16];
        words[9] = hdr.dst_ip[15:0];
    end

    always_comb begin
        sum_c = '0;
        for (int i = 0; i < $size(words); i++) begin
            sum_c = sum_c + SUM_W'(words[i]);
        end
    end

    //////////////////////////////
    // Stage 1
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req;
        end
    end

    // Unfolded sum, held between headers
    always_ff @(posedge clk) begin
        if (req) begin
            sum_q <= sum_c;
        end
    end

    //////////////////////////////
    // Stage 2
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stat.result_valid <= 1'b0;
            stat.chksum_ok    <= 1'b0;
        end else begin
            stat.result_valid <= valid_q;
            if (valid_q) begin
                stat.chksum_ok <= (csum_fold(sum_q) == {CSUM_W{1'b1}});
            end
        end
    end

    // Fixed latency of two, one result per request
    a_result_latency : assert property (
        @(posedge clk) disable iff (!arst_n)
        stat.result_valid == $past(req, 2)
    );

endmodule

// ==== rtl/ipv4_hdr_check_top.sv ====
//////////////////////////////
// IPv4 header checker and TTL forwarder with statistics
//////////////////////////////

module ipv4_hdr_check_top (
    input  logic                                clk,
    input  logic                                arst_n,

    // Header in
    input  logic                                req,
    input  ipv4_hdr_pkg::ipv4_hdr_t             in_hdr,

    // Result, two cycles after req
    output logic                                output_valid,
    output logic                                chksum_valid,
    output logic                                expired,
    output ipv4_hdr_pkg::ipv4_hdr_t             out_hdr,

    // Register port
    input  logic                                reg_wr,
    input  logic [ipv4_hdr_pkg::REG_ADDR_W-1:0] reg_addr,
    input  logic [ipv4_hdr_pkg::CNT_W-1:0]      reg_wdata,
    output logic [ipv4_hdr_pkg::CNT_W-1:0]      reg_rdata
);

    ipv4_stat_if stat ();

    //////////////////////////////
    // Datapath
    //////////////////////////////

    // Both stages see the same header on the same req
    ipv4_checksum_verify u_verify (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .req    ( req    ),
        .hdr    ( in_hdr ),
        .stat   ( stat   )
    );

    ipv4_ttl_forward u_forward (
        .clk     ( clk     ),
        .arst_n  ( arst_n  ),
        .req     ( req     ),
        .hdr     ( in_hdr  ),
        .stat    ( stat    ),
        .out_hdr ( out_hdr )
    );

    //////////////////////////////
    // Statistics
    //////////////////////////////

    ipv4_hdr_stats_regs u_stats (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .stat      ( stat      ),
        .reg_wr    ( reg_wr    ),
        .reg_addr  ( reg_addr  ),
        .reg_wdata ( reg_wdata ),
        .reg_rdata ( reg_rdata )
    );

    // Result flags straight from the interface
    assign output_valid = stat.result_valid;
    assign chksum_valid = stat.chksum_ok;
    assign expired      = stat.expired;

endmodule

// ==== rtl/ipv4_hdr_pkg.sv ====
//////////////////////////////
// IPv4 header checker shared types, register map and checksum helpers
//////////////////////////////

package ipv4_hdr_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    // Ones-complement word width
    localparam int CSUM_W = 16;

    // Unfolded sum, room for ten words plus carries
    localparam int SUM_W = 20;

    // Counter and register data width
    localparam int CNT_W = 32;

    localparam int REG_ADDR_W = 2;

    //////////////////////////////
    // Register map
    //////////////////////////////

    // Bit 0 is dec_ttl_en, other bits read zero
    localparam logic [REG_ADDR_W-1:0] REG_CTRL    = 2'd0;
    localparam logic [REG_ADDR_W-1:0] REG_GOOD    = 2'd1;
    localparam logic [REG_ADDR_W-1:0] REG_BAD     = 2'd2;
    localparam logic [REG_ADDR_W-1:0] REG_EXPIRED = 2'd3;

    //////////////////////////////
    // Header layout
    //////////////////////////////

    // Version 4, IHL 5, no options
    localparam logic [7:0] IPV4_VER_IHL = 8'h45;

    // Fields after the fixed version/IHL byte, 152 bits
    typedef struct packed {
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] frag_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] hdr_chksum;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
    } ipv4_hdr_t;

    // End-around carry, applied twice so no carry can remain
    function automatic logic [CSUM_W-1:0] csum_fold(input logic [SUM_W-1:0] sum);
        logic [SUM_W-1:0] t;
        t = SUM_W'(sum[CSUM_W-1:0]) + SUM_W'(sum[SUM_W-1:CSUM_W]);
        t = SUM_W'(t[CSUM_W-1:0]) + SUM_W'(t[CSUM_W]);
        return t[CSUM_W-1:0];
    endfunction

endpackage

// ==== rtl/ipv4_hdr_stats_regs.sv ====
//////////////////////////////
// Control bit and good/bad/expired header counters
//////////////////////////////

module ipv4_hdr_stats_regs (
    input  logic                                clk,
    input  logic                                arst_n,
    ipv4_stat_if.sink                           stat,
    input  logic                                reg_wr,
    input  logic [ipv4_hdr_pkg::REG_ADDR_W-1:0] reg_addr,
    input  logic [ipv4_hdr_pkg::CNT_W-1:0]      reg_wdata,
    output logic [ipv4_hdr_pkg::CNT_W-1:0]      reg_rdata
);

    import ipv4_hdr_pkg::*;

    // Counters indexed by their register address
    logic [CNT_W-1:0] cnt_q   [REG_GOOD:REG_EXPIRED];
    logic             cnt_inc [REG_GOOD:REG_EXPIRED];
    logic             cnt_clr [REG_GOOD:REG_EXPIRED];

    //////////////////////////////
    // Control register
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stat.dec_ttl_en <= 1'b1;
        end else if (reg_wr && reg_addr == REG_CTRL) begin
            stat.dec_ttl_en <= reg_wdata[0];
        end
    end

    //////////////////////////////
    // Counters
    //////////////////////////////

    always_comb begin
        cnt_inc[REG_GOOD]    = stat.result_valid && stat.chksum_ok;
        cnt_inc[REG_BAD]     = stat.result_valid && !stat.chksum_ok;
        cnt_inc[REG_EXPIRED] = stat.result_valid && stat.expired;
    end

    // Any write to a counter address clears it
    always_comb begin
        for (int i = REG_GOOD; i <= REG_EXPIRED; i++) begin
            cnt_clr[i] = reg_wr && (reg_addr == REG_ADDR_W'(i));
        end
    end

    // Clear wins over a same-edge increment; counters wrap
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = REG_GOOD; i <= REG_EXPIRED; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = REG_GOOD; i <= REG_EXPIRED; i++) begin
                if (cnt_clr[i]) begin
                    cnt_q[i] <= '0;
                end else if (cnt_inc[i]) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // Readback
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_rdata <= '0;
        end else begin
            case (reg_addr)
                REG_CTRL:    reg_rdata <= CNT_W'(stat.dec_ttl_en);
                REG_GOOD:    reg_rdata <= cnt_q[REG_GOOD];
                REG_BAD:     reg_rdata <= cnt_q[REG_BAD];
                REG_EXPIRED: reg_rdata <= cnt_q[REG_EXPIRED];
                default:     reg_rdata <= '0;
            endcase
        end
    end

    // Host sees clean data whatever address it drives
    a_rdata_known : assert property (
        @(posedge clk) disable iff (!arst_n)
        !$isunknown(reg_rdata)
    );

endmodule

// ==== rtl/ipv4_stat_if.sv ====
//////////////////////////////
// Per-header result pulses and TTL control
//////////////////////////////

interface ipv4_stat_if;

    // One pulse per header, two cycles after req
    logic result_valid;
    // Valid only with result_valid
    logic chksum_ok;
    // Aligned with result_valid
    logic expired;
    // Level from the control register
    logic dec_ttl_en;

    modport src (
        output result_valid,
        output chksum_ok,
        output expired,
        input  dec_ttl_en
    );

    modport sink (
        input  result_valid,
        input  chksum_ok,
        input  expired,
        output dec_ttl_en
    );

endinterface

// ==== rtl/ipv4_ttl_forward.sv ====
//////////////////////////////
// TTL decrement with incremental checksum patch (RFC 1624)
//////////////////////////////

module ipv4_ttl_forward (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    req,
    input  ipv4_hdr_pkg::ipv4_hdr_t hdr,
    ipv4_stat_if.src                stat,
    output ipv4_hdr_pkg::ipv4_hdr_t out_hdr
);

    import ipv4_hdr_pkg::*;

    logic [CSUM_W-1:0] old_tp;
    logic [CSUM_W-1:0] new_tp;
    logic [CSUM_W-1:0] inv_tp;
    logic [CSUM_W-1:0] inv_chk;
    logic [SUM_W-1:0]  patch_sum;
    logic              ttl_expire;

    ipv4_hdr_t         hdr_q;
    logic [SUM_W-1:0]  sum_q;
    logic              valid_q;
    logic              dec_q;
    logic              expired_q;
    ipv4_hdr_t         fwd_hdr;

    //////////////////////////////
    // Stage 1
    //////////////////////////////

    // TTL of 0 or 1 cannot be forwarded
    assign ttl_expire = (hdr.ttl <= 8'd1);

    // HC' = ~(~HC + ~m + m')
    assign old_tp    = {hdr.ttl, hdr.protocol};
    assign new_tp    = {hdr.ttl - 8'd1, hdr.protocol};
    assign inv_tp    = ~old_tp;
    assign inv_chk   = ~hdr.hdr_chksum;
    assign patch_sum = SUM_W'(inv_chk) + SUM_W'(inv_tp) + SUM_W'(new_tp);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q   <= 1'b0;
            expired_q <= 1'b0;
        end else begin
            valid_q   <= req;
            expired_q <= req && ttl_expire;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            hdr_q <= hdr;
            sum_q <= patch_sum;
            dec_q <= stat.dec_ttl_en && !ttl_expire;
        end
    end

    //////////////////////////////
    // Stage 2
    //////////////////////////////

    always_comb begin
        fwd_hdr = hdr_q;
        if (dec_q) begin
            fwd_hdr.ttl        = hdr_q.ttl - 8'd1;
            fwd_hdr.hdr_chksum = ~csum_fold(sum_q);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stat.expired <= 1'b0;
        end else begin
            stat.expired <= expired_q;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_q) begin
            out_hdr <= fwd_hdr;
        end
    end

    // Expired headers leave untouched
    a_expired_passthru : assert property (
        @(posedge clk) disable iff (!arst_n)
        stat.expired |-> (out_hdr == $past(hdr, 2))
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the IPv4 header checker testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --top-module ipv4_hdr_check_tb \
    -Mdir obj_dir -o ipv4_hdr_check_sim -f verilog.f

# A failing run exits nonzero, the log decides the result
./obj_dir/ipv4_hdr_check_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "CHECKS FAILED" "$LOG"; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

// ==== sim/ipv4_hdr_check_tb.sv ====
//////////////////////////////
// Testbench for the IPv4 header checker and forwarder
//////////////////////////////

module ipv4_hdr_check_tb;

    import ipv4_hdr_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int CHK_W      = 152;
    localparam int MAX_WAIT   = 4;
    localparam int BURST      = 8;
    // Tests need about 150 cycles
    localparam int WATCHDOG_CYCLES = 400;

    logic                  clk = 1'b0;
    logic                  arst_n;
    logic                  req;
    ipv4_hdr_t             in_hdr;
    logic                  output_valid;
    logic                  chksum_valid;
    logic                  expired;
    ipv4_hdr_t             out_hdr;
    logic                  reg_wr;
    logic [REG_ADDR_W-1:0] reg_addr;
    logic [CNT_W-1:0]      reg_wdata;
    logic [CNT_W-1:0]      reg_rdata;

    int   seed = 53;
    logic dec_en_model = 1'b1;
    int   good_total = 0;
    int   bad_total = 0;
    int   expired_total = 0;

    ipv4_hdr_check_top DUT (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .req          ( req          ),
        .in_hdr       ( in_hdr       ),
        .output_valid ( output_valid ),
        .chksum_valid ( chksum_valid ),
        .expired      ( expired      ),
        .out_hdr      ( out_hdr      ),
        .reg_wr       ( reg_wr       ),
        .reg_addr     ( reg_addr     ),
        .reg_wdata    ( reg_wdata    ),
        .reg_rdata    ( reg_rdata    )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog timeout, run still busy after %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $fatal(1);
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // End-around carry until nothing is left above bit 15
    function automatic logic [15:0] fold_carries(input logic [31:0] sum);
        logic [31:0] s;
        s = sum;
        while (s[31:16] != 16'h0) begin
            s = {16'h0, s[15:0]} + {16'h0, s[31:16]};
        end
        return s[15:0];
    endfunction

    function automatic logic [31:0] header_word_sum(input ipv4_hdr_t h);
        logic [31:0] s;
        s = {16'h0, IPV4_VER_IHL, h.dscp, h.ecn};
        s = s + {16'h0, h.length} + {16'h0, h.identification};
        s = s + {16'h0, h.flags, h.frag_offset} + {16'h0, h.ttl, h.protocol};
        s = s + {16'h0, h.hdr_chksum};
        s = s + {16'h0, h.src_ip[31:16]} + {16'h0, h.src_ip[15:0]};
        s = s + {16'h0, h.dst_ip[31:16]} + {16'h0, h.dst_ip[15:0]};
        return s;
    endfunction

    // Checksum field counted as zero
    function automatic logic [15:0] full_checksum(input ipv4_hdr_t h);
        ipv4_hdr_t z;
        z            = h;
        z.hdr_chksum = 16'h0;
        return ~fold_carries(header_word_sum(z));
    endfunction

    // RFC 1624 eqn 3 on the ttl/protocol word
    function automatic logic [15:0] patched_checksum(input ipv4_hdr_t h);
        logic [15:0] inv_chk;
        logic [15:0] inv_old;
        logic [15:0] new_word;
        inv_chk  = ~h.hdr_chksum;
        inv_old  = ~{h.ttl, h.protocol};
        new_word = {h.ttl - 8'd1, h.protocol};
        return ~fold_carries({16'h0, inv_chk} + {16'h0, inv_old} + {16'h0, new_word});
    endfunction

    function automatic ipv4_hdr_t forwarded_header(input ipv4_hdr_t h, input logic dec_en);
        ipv4_hdr_t r;
        r = h;
        if (dec_en && h.ttl > 8'd1) begin
            r.ttl        = h.ttl - 8'd1;
            r.hdr_chksum = patched_checksum(h);
        end
        return r;
    endfunction

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic check(input string name, input logic [CHK_W-1:0] actual,
                         input logic [CHK_W-1:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    // Random fields with a correct checksum
    task automatic random_header(output ipv4_hdr_t h, input logic forwardable);
        logic [159:0] r;
        r = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
        h = r[CHK_W-1:0];
        if (forwardable && h.ttl < 8'd2) begin
            h.ttl = h.ttl + 8'd2;
        end
        h.hdr_chksum = full_checksum(h);
    endtask

    task automatic tally_result(input logic ok, input logic expd);
        if (ok) begin
            good_total++;
        end else begin
            bad_total++;
        end
        if (expd) begin
            expired_total++;
        end
    endtask

    task automatic wait_for_output();
        int n;
        n = 0;
        while (output_valid !== 1'b1) begin
            if (n == MAX_WAIT) begin
                $display("No output_valid within %0d cycles of req", MAX_WAIT);
                $display("CHECKS FAILED");
                $fatal(1);
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic send_header(input ipv4_hdr_t h, input logic exp_ok);
        ipv4_hdr_t exp_hdr;
        logic      exp_expired;
        exp_hdr     = forwarded_header(h, dec_en_model);
        exp_expired = (h.ttl <= 8'd1);
        @(negedge clk);
        req    = 1'b1;
        in_hdr = h;
        @(negedge clk);
        req = 1'b0;
        wait_for_output();
        check("chksum_valid", CHK_W'(chksum_valid), CHK_W'(exp_ok));
        check("expired", CHK_W'(expired), CHK_W'(exp_expired));
        check("out_hdr", out_hdr, exp_hdr);
        tally_result(exp_ok, exp_expired);
    endtask

    task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [CNT_W-1:0] data);
        @(negedge clk);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_wr = 1'b0;
    endtask

    // Registered readback lands one cycle after the address
    task automatic read_reg(input logic [REG_ADDR_W-1:0] addr, output logic [CNT_W-1:0] data);
        @(negedge clk);
        reg_wr   = 1'b0;
        reg_addr = addr;
        @(negedge clk);
        data = reg_rdata;
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic good_header();
        ipv4_hdr_t h;
        ipv4_hdr_t next_hdr;
        random_header(h, 1'b1);
        send_header(h, 1'b1);
        next_hdr     = h;
        next_hdr.ttl = h.ttl - 8'd1;
        check("out_hdr.ttl", CHK_W'(out_hdr.ttl), CHK_W'(next_hdr.ttl));
        check("out_hdr.hdr_chksum", CHK_W'(out_hdr.hdr_chksum),
              CHK_W'(full_checksum(next_hdr)));
    endtask

    task automatic bad_header();
        ipv4_hdr_t  h;
        logic [3:0] bit_sel;
        random_header(h, 1'b1);
        bit_sel = 4'($random(seed));
        h.identification[bit_sel] = ~h.identification[bit_sel];
        send_header(h, 1'b0);
    endtask

    task automatic ttl_expiry();
        ipv4_hdr_t h;
        for (int t = 0; t < 2; t++) begin
            random_header(h, 1'b0);
            h.ttl        = 8'(t);
            h.hdr_chksum = full_checksum(h);
            send_header(h, 1'b1);
            check("out_hdr", out_hdr, h);
        end
    endtask

    task automatic back_to_back();
        ipv4_hdr_t h;
        ipv4_hdr_t exp_hdr;
        ipv4_hdr_t hdr_q[$];
        logic      ok_q[$];
        logic      expired_q[$];
        logic      ok;
        logic      expd;
        fork
            begin
                for (int i = 0; i < BURST; i++) begin
                    random_header(h, 1'b0);
                    // Every third header corrupted
                    if (i % 3 == 1) begin
                        h.identification[i] = ~h.identification[i];
                    end
                    hdr_q.push_back(forwarded_header(h, dec_en_model));
                    ok_q.push_back(i % 3 != 1);
                    expired_q.push_back(h.ttl <= 8'd1);
                    @(negedge clk);
                    req    = 1'b1;
                    in_hdr = h;
                end
                @(negedge clk);
                req = 1'b0;
            end
            begin
                // Result of the previous header may still be on the outputs
                @(negedge clk);
                wait_for_output();
                for (int k = 0; k < BURST; k++) begin
                    if (k > 0) begin
                        @(negedge clk);
                    end
                    check("output_valid", CHK_W'(output_valid), CHK_W'(1'b1));
                    exp_hdr = hdr_q.pop_front();
                    ok      = ok_q.pop_front();
                    expd    = expired_q.pop_front();
                    check("chksum_valid", CHK_W'(chksum_valid), CHK_W'(ok));
                    check("expired", CHK_W'(expired), CHK_W'(expd));
                    check("out_hdr", out_hdr, exp_hdr);
                    tally_result(ok, expd);
                end
            end
        join
    endtask

    task automatic ttl_control();
        ipv4_hdr_t        h;
        logic [CNT_W-1:0] ctrl;
        write_reg(REG_CTRL, '0);
        dec_en_model = 1'b0;
        read_reg(REG_CTRL, ctrl);
        check("reg_rdata ctrl", CHK_W'(ctrl), '0);
        random_header(h, 1'b1);
        send_header(h, 1'b1);
        check("out_hdr", out_hdr, h);
        write_reg(REG_CTRL, CNT_W'(1));
        dec_en_model = 1'b1;
    endtask

    task automatic counter_readback();
        logic [CNT_W-1:0] value;
        read_reg(REG_GOOD, value);
        check("reg_rdata good", CHK_W'(value), CHK_W'(good_total));
        read_reg(REG_BAD, value);
        check("reg_rdata bad", CHK_W'(value), CHK_W'(bad_total));
        read_reg(REG_EXPIRED, value);
        check("reg_rdata expired", CHK_W'(value), CHK_W'(expired_total));
        // A write of any value clears a counter
        for (int a = 1; a <= 3; a++) begin
            write_reg(REG_ADDR_W'(a), CNT_W'(32'h5a5a));
            read_reg(REG_ADDR_W'(a), value);
            check($sformatf("reg_rdata addr %0d", a), CHK_W'(value), '0);
        end
    endtask

    initial begin
        arst_n    = 1'b0;
        req       = 1'b0;
        in_hdr    = '0;
        reg_wr    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        check("output_valid", CHK_W'(output_valid), '0);
        good_header();
        bad_header();
        ttl_expiry();
        back_to_back();
        ttl_control();
        counter_readback();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== verilog.f ====
rtl/ipv4_hdr_pkg.sv
rtl/ipv4_stat_if.sv
rtl/ipv4_checksum_verify.sv
rtl/ipv4_ttl_forward.sv
rtl/ipv4_hdr_stats_regs.sv
rtl/ipv4_hdr_check_top.sv
sim/ipv4_hdr_check_tb.sv
